// File: tb.f
hdl/pet_pkg.sv
hdl/bus_timer.sv
hdl/pi_sync.sv
hdl/bus_decode.sv
hdl/pi_regs.sv
hdl/pet_bus_top.sv
bench/tb_clock.sv
bench/tb_pet_bus.sv

// File: run.sh
#!/bin/sh
# Build the PET bus core testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_pet_bus -f tb.f -o sim_pet_bus
./obj_dir/sim_pet_bus > sim.log 2>&1 || true
cat sim.log

if grep -q "Result: FAILED" sim.log; then
    exit 1
fi
exit 0

// File: bench/tb_pet_bus.sv
// PET bus core testbench covering slot timing, reset state, Pi handshake, CPU decode and RAM mux
`timescale 1ns/1ps

module tb_pet_bus;

    localparam logic [16:0] CTL = pet_pkg::CTL_ADDR_DEF;
    localparam logic [16:0] GFX = pet_pkg::GFX_ADDR_DEF;

    logic        clk16;
    logic        rst;
    logic [16:0] cpu_addr;
    logic        cpu_rw_b;
    logic [16:0] pi_addr;
    logic        pi_rw_b;
    logic [7:0]  pi_wr_data;
    logic        pi_pending;
    logic [11:0] video_addr;
    logic [7:0]  ram_data;
    logic        gfx;
    logic        phi2;
    logic        video_ram_strobe;
    logic        video_rom_strobe;
    logic        pi_done;
    logic [7:0]  pi_rd_data;
    logic        res_b;
    logic        rdy;
    logic        cpu_be;
    logic        pia1_cs2_b;
    logic        pia2_cs2_b;
    logic        via_cs2_b;
    logic        io_oe_b;
    logic        ram_ce_b;
    logic        ram_oe_b;
    logic        ram_we_b;
    logic [1:0]  ram_addr_hi;

    logic [3:0]  tslot;         // Expected slot count, tracked from reset
    logic [31:0] lfsr;
    logic        grant_req;     // Request seen at the grant count
    logic        exp_rdy;
    logic [7:0]  strobe_data;   // ram_data present in the last strobe cycle
    int          err_count;
    int          check_count;
    int          test_errs;
    int          k;
    int          n;

    tb_clock clk_i (.clk(clk16));

    pet_bus_top dut_i (.*);

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);   // Taps 32, 30, 26, 25
    endfunction

    function automatic logic [15:0] rand_bits(input int bits);
        logic [15:0] r;
        int i;
        r = '0;
        for (i = 0; i < bits; i++) begin
            lfsr = lfsr_step(lfsr);
            r = {r[14:0], lfsr[0]};     // One step per bit
        end
        return r;
    endfunction

    function automatic logic in_range(input logic [16:0] a, input logic [15:0] lo,
                                      input logic [15:0] hi);
        return !a[16] && (a[15:0] >= lo) && (a[15:0] <= hi);
    endfunction

    function automatic logic read_only(input logic [16:0] a);
        return in_range(a, 16'h9000, 16'hE7FF) || in_range(a, 16'hF000, 16'hFFFF);
    endfunction

    // {pia1, pia2, via, io}, active low
    function automatic logic [3:0] decode_selects(input logic [16:0] a, input logic be);
        logic [3:0] hit;
        hit = {in_range(a, 16'hE810, 16'hE81F), in_range(a, 16'hE820, 16'hE82F),
               in_range(a, 16'hE840, 16'hE84F), in_range(a, 16'hE800, 16'hEFFF)};
        return ~(hit & {4{be}});
    endfunction

    // {ram_ce_b, ram_oe_b, ram_we_b}
    function automatic logic [2:0] model_ram_strobes(input logic [16:0] a, input logic rw_b,
                                                     input logic [3:0] s, input logic be,
                                                     input logic p_rd, input logic p_wr);
        logic ce;
        logic oe;
        logic we;
        ce = (s < 4'd8) || !in_range(a, 16'hE800, 16'hEFFF);
        oe = p_rd || (s >= 4'd4 && s <= 4'd7) || (rw_b && s >= 4'd12 && be);
        we = p_wr || (!rw_b && s >= 4'd12 && be && !read_only(a));
        return ~{ce, oe, we};
    endfunction

    function automatic logic [1:0] pick_addr_hi(input logic [3:0] s, input logic [16:0] ca,
                                                input logic [16:0] pa, input logic [11:0] va);
        if (s < 4'd4) return pa[11:10];
        if (s < 4'd8) return va[11:10];
        if (in_range(ca, 16'h8000, 16'h8FFF)) return 2'b00;    // Video RAM fold
        return ca[11:10];
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("[FAIL] %0t ns %s: got %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic end_test(input string name);
        $display("test %-16s %0d errors", name, err_count - test_errs);
        test_errs = err_count;
    endtask

    // One pending/done handshake, read data checked when pi_done rises
    task automatic pi_access(input logic [16:0] a, input logic rw_b, input logic [7:0] wd);
        int waited;
        @(negedge clk16);
        pi_addr    = a;
        pi_rw_b    = rw_b;
        pi_wr_data = wd;
        pi_pending = 1'b1;
        waited     = 0;
        while (!pi_done && waited < 18) begin
            @(negedge clk16);
            waited++;
            ram_data = 8'(rand_bits(8));
            if (tslot == 4'd2) strobe_data = ram_data;     // Sampled by the strobe edge
        end
        if (!pi_done) begin
            err_count++;
            $display("Pi access to %0h got no pi_done within 18 cycles", a);
        end else if (rw_b) begin
            check("pi_rd_data", pi_rd_data, (a == GFX) ? {7'd0, gfx} : strobe_data);
        end else if (a == CTL) begin
            exp_rdy = wd[1];
        end
        pi_pending = 1'b0;
        waited = 0;
        while (pi_done && waited < 4) begin
            @(negedge clk16);
            waited++;
        end
        if (pi_done) begin
            err_count++;
            $display("pi_done stayed high after pi_pending fell");
        end
    endtask

    always @(posedge clk16) begin
        if (rst) tslot <= 4'd0;
        else tslot <= tslot + 4'd1;     // Wraps at 15
    end

    // Compare against the reference map in the low phase of every cycle
    always begin : compare_outputs
        logic       strobe;
        logic       be;
        logic [3:0] sel;
        logic [2:0] ram;
        @(negedge clk16);
        #5;
        if (rst) begin
            grant_req = 1'b0;
        end else begin
            strobe = (tslot == 4'd2) && grant_req;         // Pi strobe only on count 2
            if (tslot == 4'd1) grant_req = pi_pending;     // Held request meets the grant
            be  = (tslot >= 4'd8) && exp_rdy;
            sel = decode_selects(cpu_addr, be);
            ram = model_ram_strobes(cpu_addr, cpu_rw_b, tslot, be, strobe && pi_rw_b,
                                    strobe && !pi_rw_b);
            check("cpu_be", cpu_be, be);
            check("pia1_cs2_b", pia1_cs2_b, sel[3]);
            check("pia2_cs2_b", pia2_cs2_b, sel[2]);
            check("via_cs2_b", via_cs2_b, sel[1]);
            check("io_oe_b", io_oe_b, sel[0]);
            check("ram_ce_b", ram_ce_b, ram[2]);
            check("ram_oe_b", ram_oe_b, ram[1]);
            check("ram_we_b", ram_we_b, ram[0]);
            check("ram_addr_hi", ram_addr_hi, pick_addr_hi(tslot, cpu_addr, pi_addr, video_addr));
        end
    end

    initial begin
        #500_000;
        $display("Simulation did not finish within its time limit");
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        lfsr        = 32'h392c_8db8;
        err_count   = 0;
        check_count = 0;
        test_errs   = 0;
        exp_rdy     = 1'b0;
        grant_req   = 1'b0;
        strobe_data = '0;
        rst         = 1'b1;
        cpu_addr    = '0;
        cpu_rw_b    = 1'b1;
        pi_addr     = '0;
        pi_rw_b     = 1'b1;
        pi_wr_data  = '0;
        pi_pending  = 1'b0;
        video_addr  = '0;
        ram_data    = '0;
        gfx         = 1'b0;
        repeat (3) @(posedge clk16);
        @(negedge clk16);
        rst = 1'b0;

        repeat (16) begin       // CPU held and halted for a whole CPU cycle
            @(negedge clk16);
            check("res_b", res_b, 1'b0);
            check("rdy", rdy, 1'b0);
            check("pi_done", pi_done, 1'b0);
            check("cpu_be", cpu_be, 1'b0);
            check("chip selects", {pia1_cs2_b, pia2_cs2_b, via_cs2_b, io_oe_b}, 4'hF);
            check("ram_we_b", ram_we_b, 1'b1);
        end
        end_test("reset state");

        n = 0;
        while (phi2 && n < 20) begin
            @(negedge clk16);
            n++;
        end
        while (!phi2 && n < 40) begin
            @(negedge clk16);
            n++;
        end
        if (!phi2) begin
            err_count++;
            $display("phi2 never rose after reset");
        end
        for (k = 0; k < 64; k++) begin     // k counts cycles from the phi2 rise
            check("phi2", phi2, (k % 16) < 4);
            check("video_ram_strobe", video_ram_strobe, (k % 16) == 9);    // Count 5
            check("video_rom_strobe", video_rom_strobe, (k % 16) == 11);   // Count 7
            @(negedge clk16);
        end
        end_test("slot pattern");

        for (k = 0; k < 4; k++) begin
            pi_access(CTL, 1'b0, 8'(k));
            check("res_b", res_b, k[0]);
            check("rdy", rdy, k[1]);
        end
        pi_access(CTL - 17'd1, 1'b0, 8'h00);  // Neighbour address, control bits stay set
        check("res_b", res_b, 1'b1);
        check("rdy", rdy, 1'b1);
        end_test("control register");

        for (k = 0; k < 200; k++) begin
            n = 0;
            while (tslot != 4'd8 && n < 16) begin
                @(negedge clk16);
                n++;
            end
            // A quarter of the addresses land in the IO page
            cpu_addr = (rand_bits(2) == 16'd0) ? {1'b0, 16'hE800 | rand_bits(8)}
                                               : {1'b0, rand_bits(16)};
            cpu_rw_b = (rand_bits(1) != 16'd0);
            repeat (5) @(negedge clk16);
            #5;
            if (!cpu_rw_b && read_only(cpu_addr)) check("ram_we_b", ram_we_b, 1'b1);
        end
        end_test("cpu decode");

        for (k = 0; k < 16; k++) begin
            @(negedge clk16);
            cpu_addr   = k[0] ? {1'b0, 16'h8000 | rand_bits(12)} : {1'b0, rand_bits(16)};
            video_addr = 12'(rand_bits(12));
            pi_access({k[1], rand_bits(16)}, 1'b1, 8'h00);
        end
        end_test("ram address mux");

        gfx = 1'b1;
        pi_access(GFX, 1'b1, 8'h00);
        gfx = 1'b0;
        pi_access(GFX, 1'b1, 8'h00);
        for (k = 0; k < 8; k++) begin
            pi_access({1'b0, rand_bits(16)}, 1'b1, 8'h00);
        end
        end_test("pi read data");

        $display("checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: bench/tb_clock.sv
// Testbench clock source, free-running with a 20 ns period
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    initial clk = 1'b0;
    always #10 clk = ~clk;      // Half period

endmodule

// File: hdl/pet_bus_top.sv
// PET bus core top: slot timer, Pi handshake, address decoder and Pi registers
`timescale 1ns/1ps

module pet_bus_top #(
    parameter logic [pet_pkg::ADDR_W-1:0] CTL_ADDR = pet_pkg::CTL_ADDR_DEF,
    parameter logic [pet_pkg::ADDR_W-1:0] GFX_ADDR = pet_pkg::GFX_ADDR_DEF
) (
    input  logic                        clk16,          // 16 MHz master clock
    input  logic                        rst,
    // CPU side
    input  logic [pet_pkg::ADDR_W-1:0]  cpu_addr,
    input  logic                        cpu_rw_b,
    // Pi side
    input  logic [pet_pkg::ADDR_W-1:0]  pi_addr,
    input  logic                        pi_rw_b,
    input  logic [pet_pkg::DATA_W-1:0]  pi_wr_data,
    input  logic                        pi_pending,
    // Video and board inputs
    input  logic [pet_pkg::VADDR_W-1:0] video_addr,
    input  logic [pet_pkg::DATA_W-1:0]  ram_data,
    input  logic                        gfx,
    // Timing outputs
    output logic                        phi2,           // 1 MHz CPU clock
    output logic                        video_ram_strobe,
    output logic                        video_rom_strobe,
    // Pi outputs
    output logic                        pi_done,
    output logic [pet_pkg::DATA_W-1:0]  pi_rd_data,
    // CPU control
    output logic                        res_b,
    output logic                        rdy,
    output logic                        cpu_be,
    // Selects and RAM
    output logic                        pia1_cs2_b,
    output logic                        pia2_cs2_b,
    output logic                        via_cs2_b,
    output logic                        io_oe_b,
    output logic                        ram_ce_b,
    output logic                        ram_oe_b,
    output logic                        ram_we_b,
    output logic [1:0]                  ram_addr_hi
);

    logic pi_select;
    logic pi_grant;
    logic video_select;
    logic cpu_enable;
    logic pi_read;
    logic pi_write;

    bus_timer timer_i (
        .clk16(clk16), .rst(rst),
        .pi_select(pi_select), .pi_grant(pi_grant),
        .video_select(video_select),
        .video_ram_strobe(video_ram_strobe), .video_rom_strobe(video_rom_strobe),
        .cpu_enable(cpu_enable), .phi2(phi2)
    );

    pi_sync sync_i (
        .clk16(clk16), .rst(rst),
        .pi_grant(pi_grant), .pi_rw_b(pi_rw_b), .pi_pending(pi_pending),
        .pi_read(pi_read), .pi_write(pi_write), .pi_done(pi_done)
    );

    bus_decode decode_i (
        .cpu_addr(cpu_addr), .cpu_rw_b(cpu_rw_b),
        .pi_addr(pi_addr), .video_addr(video_addr),
        .pi_select(pi_select), .video_select(video_select),
        .cpu_enable(cpu_enable), .phi2(phi2),
        .pi_read(pi_read), .pi_write(pi_write), .rdy(rdy),
        .cpu_be(cpu_be),
        .pia1_cs2_b(pia1_cs2_b), .pia2_cs2_b(pia2_cs2_b),
        .via_cs2_b(via_cs2_b), .io_oe_b(io_oe_b),
        .ram_ce_b(ram_ce_b), .ram_oe_b(ram_oe_b), .ram_we_b(ram_we_b),
        .ram_addr_hi(ram_addr_hi)
    );

    pi_regs #(
        .CTL_ADDR(CTL_ADDR),
        .GFX_ADDR(GFX_ADDR)
    ) regs_i (
        .clk16(clk16), .rst(rst),
        .pi_addr(pi_addr), .pi_wr_data(pi_wr_data),
        .pi_read(pi_read), .pi_write(pi_write),
        .ram_data(ram_data), .gfx(gfx),
        .res_b(res_b), .rdy(rdy), .pi_rd_data(pi_rd_data)
    );

endmodule

// File: hdl/pi_regs.sv
// Pi register block: CPU reset/ready control bits and the latched Pi read data
`timescale 1ns/1ps

module pi_regs #(
    parameter logic [pet_pkg::ADDR_W-1:0] CTL_ADDR = pet_pkg::CTL_ADDR_DEF,
    parameter logic [pet_pkg::ADDR_W-1:0] GFX_ADDR = pet_pkg::GFX_ADDR_DEF
) (
    input  logic                       clk16,
    input  logic                       rst,
    input  logic [pet_pkg::ADDR_W-1:0] pi_addr,
    input  logic [pet_pkg::DATA_W-1:0] pi_wr_data,
    input  logic                       pi_read,       // One-cycle strobe
    input  logic                       pi_write,      // One-cycle strobe
    input  logic [pet_pkg::DATA_W-1:0] ram_data,      // RAM output during the strobe
    input  logic                       gfx,           // Graphics jumper
    output logic                       res_b,         // 0 = CPU held in reset
    output logic                       rdy,           // 0 = CPU halted
    output logic [pet_pkg::DATA_W-1:0] pi_rd_data
);

    logic [1:0] ctl;            // Bit 0 res_b, bit 1 rdy

    // Control register, loaded on the edge that ends a Pi write
    always_ff @(posedge clk16) begin
        if (rst) begin
            ctl <= 2'b00;                       // CPU in reset and halted
        end else if (pi_write && (pi_addr == CTL_ADDR)) begin
            ctl <= pi_wr_data[1:0];
        end
    end

    // Read latch, valid by the time pi_done rises
    always_ff @(posedge clk16) begin
        if (rst) begin
            pi_rd_data <= '0;
        end else if (pi_read) begin
            if (pi_addr == GFX_ADDR) begin
                pi_rd_data <= {{(pet_pkg::DATA_W-1){1'b0}}, gfx};
            end else begin
                pi_rd_data <= ram_data;         // RAM drives the bus in the Pi slot
            end
        end
    end

    assign res_b = ctl[0];
    assign rdy   = ctl[1];

endmodule

// File: hdl/bus_decode.sv
// Memory-map decoder: active-low chip selects, RAM strobes and the VRAM-folding A11/A10 mux
`timescale 1ns/1ps

module bus_decode (
    input  logic [pet_pkg::ADDR_W-1:0]  cpu_addr,
    input  logic                        cpu_rw_b,      // 1 = CPU reads
    input  logic [pet_pkg::ADDR_W-1:0]  pi_addr,
    input  logic [pet_pkg::VADDR_W-1:0] video_addr,
    input  logic                        pi_select,
    input  logic                        video_select,
    input  logic                        cpu_enable,
    input  logic                        phi2,
    input  logic                        pi_read,
    input  logic                        pi_write,
    input  logic                        rdy,
    output logic                        cpu_be,        // 1 = CPU owns the bus
    output logic                        pia1_cs2_b,
    output logic                        pia2_cs2_b,
    output logic                        via_cs2_b,
    output logic                        io_oe_b,       // IO buffer output enable
    output logic                        ram_ce_b,
    output logic                        ram_oe_b,
    output logic                        ram_we_b,
    output logic [1:0]                  ram_addr_hi    // Drives RAM A11/A10
);

    logic [15:0] addr;          // CPU-visible part of the address
    logic        upper;         // Upper 64K, treated as plain RAM
    logic        is_io;
    logic        is_ram;
    logic        is_pia1;
    logic        is_pia2;
    logic        is_via;
    logic        is_readonly;
    logic        is_mirrored;
    logic        cpu_read;
    logic        cpu_write;
    logic        ram_ce;
    logic        ram_oe;
    logic        ram_we;

    assign addr  = cpu_addr[15:0];
    assign upper = cpu_addr[pet_pkg::ADDR_W-1];

    // Region classification
    assign is_io       = !upper && (addr >= pet_pkg::IO_BASE) && (addr <= pet_pkg::IO_END);
    assign is_ram      = !is_io;                                    // Everything else is RAM
    assign is_pia1     = is_io && (addr[15:4] == pet_pkg::PIA1_BASE[15:4]);
    assign is_pia2     = is_io && (addr[15:4] == pet_pkg::PIA2_BASE[15:4]);
    assign is_via      = is_io && (addr[15:4] == pet_pkg::VIA_BASE[15:4]);
    assign is_mirrored = !upper && (addr >= pet_pkg::VRAM_BASE) && (addr <= pet_pkg::VRAM_END);
    assign is_readonly = !upper
                       && (((addr >= pet_pkg::ROM_BASE) && (addr <= pet_pkg::ROM_END))
                           || (addr >= pet_pkg::KERNAL_BASE));

    // CPU only drives the bus in its slot and when not halted
    assign cpu_be    = cpu_enable && rdy;
    assign cpu_read  = cpu_rw_b && phi2;
    assign cpu_write = !cpu_rw_b && phi2;

    // Device selects, all idle while cpu_be is low
    assign pia1_cs2_b = !(is_pia1 && cpu_be);
    assign pia2_cs2_b = !(is_pia2 && cpu_be);
    assign via_cs2_b  = !(is_via && cpu_be);
    assign io_oe_b    = !(is_io && cpu_be);

    // RAM strobes
    assign ram_ce = is_ram || !cpu_enable;                  // Pi and video slots always hit RAM
    assign ram_oe = pi_read || video_select || (cpu_read && cpu_be);
    assign ram_we = pi_write || (cpu_write && cpu_be && !is_readonly); // ROM images stay intact

    assign ram_ce_b = !ram_ce;
    assign ram_oe_b = !ram_oe;
    assign ram_we_b = !ram_we;

    // A11/A10 source, Pi first, then video, then CPU
    always_comb begin
        if (pi_select) begin
            ram_addr_hi = pi_addr[11:10];       // Pi sees all of RAM
        end else if (video_select) begin
            ram_addr_hi = video_addr[11:10];
        end else if (is_mirrored) begin
            ram_addr_hi = 2'b00;                // 8000-8FFF folds onto the first 1K
        end else begin
            ram_addr_hi = cpu_addr[11:10];
        end
    end

endmodule

// File: hdl/pi_sync.sv
// Pi handshake FSM: one RAM/register strobe per CPU cycle, answered by a level pi_done
`timescale 1ns/1ps

module pi_sync (
    input  logic clk16,
    input  logic rst,
    input  logic pi_grant,      // High on the count before the Pi strobe
    input  logic pi_rw_b,       // 1 = Pi reads, 0 = Pi writes
    input  logic pi_pending,    // Level request from the Pi
    output logic pi_read,
    output logic pi_write,
    output logic pi_done
);

    typedef enum logic [1:0] {
        IDLE,
        STROBE,
        DONE
    } state_t;

    state_t state;
    state_t state_nxt;

    always_ff @(posedge clk16) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                // Wait for the grant so the strobe lands on count 2
                if (pi_pending && pi_grant) begin
                    state_nxt = STROBE;
                end
            end
            STROBE: begin
                state_nxt = DONE;           // Single-cycle strobe
            end
            DONE: begin
                if (!pi_pending) begin
                    state_nxt = IDLE;       // Pi saw done and dropped its request
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    // Strobe direction follows the held pi_rw_b
    assign pi_read  = (state == STROBE) && pi_rw_b;
    assign pi_write = (state == STROBE) && !pi_rw_b;
    assign pi_done  = (state == DONE);

endmodule

// File: hdl/bus_timer.sv
// Bus timer: free-running slot counter that cuts each CPU cycle into Pi, video and CPU slots
`timescale 1ns/1ps

module bus_timer (
    input  logic clk16,
    input  logic rst,
    output logic pi_select,
    output logic pi_grant,
    output logic video_select,
    output logic video_ram_strobe,
    output logic video_rom_strobe,
    output logic cpu_enable,
    output logic phi2
);

    localparam logic [pet_pkg::SLOT_W-1:0] SLOT_LAST = pet_pkg::SLOT_W'(pet_pkg::SLOT_COUNT - 1);

    logic [pet_pkg::SLOT_W-1:0] slot;   // Position within the CPU cycle

    // True when s lies in [first, last], modulo arithmetic avoids a compare against zero
    function automatic logic in_window(input logic [pet_pkg::SLOT_W-1:0] s,
                                       input logic [pet_pkg::SLOT_W-1:0] first,
                                       input logic [pet_pkg::SLOT_W-1:0] last);
        logic [pet_pkg::SLOT_W-1:0] offs;
        offs = s - first;
        return offs <= (last - first);
    endfunction

    always_ff @(posedge clk16) begin
        if (rst) begin
            slot <= '0;                 // Start in the Pi slot
        end else if (slot == SLOT_LAST) begin
            slot <= '0;
        end else begin
            slot <= slot + 1'b1;
        end
    end

    // Windows and strobes, same cycle as the count
    assign pi_select        = in_window(slot, pet_pkg::SLOT_PI_FIRST, pet_pkg::SLOT_PI_LAST);
    assign pi_grant         = (slot == pet_pkg::SLOT_PI_GRANT);
    assign video_select     = in_window(slot, pet_pkg::SLOT_VID_FIRST, pet_pkg::SLOT_VID_LAST);
    assign video_ram_strobe = (slot == pet_pkg::SLOT_VID_RAM);
    assign video_rom_strobe = (slot == pet_pkg::SLOT_VID_ROM);
    assign cpu_enable       = in_window(slot, pet_pkg::SLOT_CPU_FIRST, SLOT_LAST);
    assign phi2             = in_window(slot, pet_pkg::SLOT_PHI2_FIRST, SLOT_LAST); // 4 of 16

endmodule

// File: hdl/pet_pkg.sv
// PET bus core package with bus widths, CPU-cycle slot numbers and memory-map bounds
package pet_pkg;

    // Bus widths
    localparam int ADDR_W  = 17;        // Bit 16 selects upper RAM (Pi only)
    localparam int DATA_W  = 8;
    localparam int VADDR_W = 12;        // Video fetch address from the CRTC side

    // One 1 MHz CPU cycle in clk16 ticks
    localparam int SLOT_COUNT = 16;
    localparam int SLOT_W     = $clog2(SLOT_COUNT);

    // Pi access slot
    localparam logic [SLOT_W-1:0] SLOT_PI_FIRST = 4'd0;
    localparam logic [SLOT_W-1:0] SLOT_PI_LAST  = 4'd3;
    localparam logic [SLOT_W-1:0] SLOT_PI_GRANT = 4'd1;  // Strobe follows on count 2

    // Video fetch slot
    localparam logic [SLOT_W-1:0] SLOT_VID_FIRST = 4'd4;
    localparam logic [SLOT_W-1:0] SLOT_VID_LAST  = 4'd7;
    localparam logic [SLOT_W-1:0] SLOT_VID_RAM   = 4'd5;  // Character code fetch
    localparam logic [SLOT_W-1:0] SLOT_VID_ROM   = 4'd7;  // Glyph row fetch

    // CPU slot, phi2 in its second half
    localparam logic [SLOT_W-1:0] SLOT_CPU_FIRST  = 4'd8;
    localparam logic [SLOT_W-1:0] SLOT_PHI2_FIRST = 4'd12;

    // Memory map, CPU-visible 64K
    localparam logic [15:0] VRAM_BASE   = 16'h8000;  // Video RAM, folded onto low 1K
    localparam logic [15:0] VRAM_END    = 16'h8FFF;
    localparam logic [15:0] ROM_BASE    = 16'h9000;  // BASIC/editor ROM images, read-only
    localparam logic [15:0] ROM_END     = 16'hE7FF;
    localparam logic [15:0] IO_BASE     = 16'hE800;  // IO page, never RAM
    localparam logic [15:0] IO_END      = 16'hEFFF;
    localparam logic [15:0] KERNAL_BASE = 16'hF000;  // Read-only through FFFF
    localparam logic [15:0] PIA1_BASE   = 16'hE810;  // 16 bytes each
    localparam logic [15:0] PIA2_BASE   = 16'hE820;
    localparam logic [15:0] VIA_BASE    = 16'hE840;

    // Pi-side register addresses
    localparam logic [ADDR_W-1:0] CTL_ADDR_DEF = 17'h0_E80F;  // CPU reset/ready
    localparam logic [ADDR_W-1:0] GFX_ADDR_DEF = 17'h0_E80E;  // Graphics jumper state

endpackage
